// ==== include/gf233_consts.svh ====
`ifndef GF233_CONSTS_SVH
`define GF233_CONSTS_SVH

// Field degree and middle tap of x^233 + x^74 + 1
`define GF_M 233
`define GF_TAP 74

// Multiplier bits consumed per cycle, 1, 4, 8 or 16
`define GF_DIGIT 8
`define GF_DIGITS ((`GF_M + `GF_DIGIT - 1) / `GF_DIGIT)

// Square-and-multiply rounds for a^(2^m - 2)
`define GF_INV_ROUNDS (`GF_M - 1)

`endif

// ==== rtl/gf233_pkg.sv ====
`default_nettype none

`include "gf233_consts.svh"

package gf233_pkg;

  // Bit i is the coefficient of x^i
  typedef logic [`GF_M-1:0] gf_elem_t;

  typedef enum logic [1:0] {
    op_sqr = 2'd0,
    op_mul = 2'd1,
    op_inv = 2'd2
  } gf_op_e;

  typedef struct packed {
    gf_op_e   op;
    gf_elem_t a;
    gf_elem_t b;  // Read by op_mul only
  } gf_req_t;

  typedef struct packed {
    gf_op_e   op;
    gf_elem_t result;
  } gf_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/gf233_squarer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gf233_consts.svh"

module gf233_squarer import gf233_pkg::*; (
  input  gf_elem_t a,
  output gf_elem_t d
);
  localparam int half = (`GF_M + 1) / 2;  // First coefficient that wraps past x^232
  localparam int tap_half = `GF_TAP / 2;

  genvar i;

  // Even bits keep the low half of a, plus the terms that wrap around twice
  for (i = 0; i < half; i++) begin : g_even
    if (i < tap_half) begin : g_top
      assign d[2*i] = a[i] ^ a[`GF_M - tap_half + i];
    end else if (i < `GF_TAP) begin : g_mid
      assign d[2*i] = a[i] ^ a[`GF_M - `GF_TAP + i];
    end else begin : g_low
      assign d[2*i] = a[i];
    end
  end

  // Odd bits come only from the upper half, folded once through x^74 + 1
  for (i = 0; i < half - 1; i++) begin : g_odd
    if (i < tap_half) begin : g_plain
      assign d[2*i+1] = a[half + i];
    end else begin : g_fold
      assign d[2*i+1] = a[half + i] ^ a[half - tap_half + i];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/gf233_digit_mul.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gf233_consts.svh"

module gf233_digit_mul import gf233_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  input  logic     step,
  input  gf_elem_t x,
  input  gf_elem_t y,
  output gf_elem_t product
);
  localparam int pad_w = `GF_DIGITS * `GF_DIGIT;
  localparam int wide_w = `GF_M + `GF_DIGIT;

  logic [pad_w-1:0]     x_sr;
  logic [`GF_DIGIT-1:0] digit;
  logic [wide_w-1:0]    wide;
  gf_elem_t             fold;
  gf_elem_t             acc;
  gf_elem_t             acc_next;

  // The zero padding sits above x, so the first digit carries x^232 and up
  assign digit = x_sr[pad_w-1 -: `GF_DIGIT];

  always_comb begin
    wide = {acc, {`GF_DIGIT{1'b0}}};  // Horner step, acc times x^D
    for (int k = 0; k < `GF_DIGIT; k++) begin
      if (digit[k]) begin
        wide = wide ^ ({{`GF_DIGIT{1'b0}}, y} << k);
      end
    end

    // Overflow past x^232 maps to x^k + x^(74+k), which stays below the degree
    fold = {{(`GF_M - `GF_DIGIT){1'b0}}, wide[wide_w-1 -: `GF_DIGIT]};
    acc_next = wide[`GF_M-1:0] ^ fold ^ (fold << `GF_TAP);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (start) begin
      acc <= '0;
    end else if (step) begin
      acc <= acc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      x_sr <= {{(pad_w - `GF_M){1'b0}}, x};
    end else if (step) begin
      x_sr <= x_sr << `GF_DIGIT;  // Next digit moves to the top
    end
  end

  assign product = acc;

endmodule

`default_nettype wire

// ==== rtl/gf233_step_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gf233_consts.svh"

module gf233_step_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic load_digits,
  input  logic step_digit,
  input  logic load_rounds,
  input  logic step_round,
  output logic digit_last,
  output logic round_last
);
  localparam int digit_w = $clog2(`GF_DIGITS);
  localparam int round_w = $clog2(`GF_INV_ROUNDS);

  logic [digit_w-1:0] digit_cnt;
  logic [round_w-1:0] round_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      digit_cnt <= '0;
      round_cnt <= '0;
    end else begin
      if (load_digits) digit_cnt <= digit_w'(`GF_DIGITS - 1);
      else if (step_digit) digit_cnt <= digit_cnt - 1'b1;

      if (load_rounds) round_cnt <= round_w'(`GF_INV_ROUNDS - 1);
      else if (step_round) round_cnt <= round_cnt - 1'b1;
    end
  end

  assign digit_last = (digit_cnt == '0);
  assign round_last = (round_cnt == '0);

endmodule

`default_nettype wire

// ==== rtl/gf233_ctrl_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module gf233_ctrl_fsm import gf233_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   start,
  input  gf_op_e op,
  input  logic   digit_last,
  input  logic   round_last,
  output logic   load_op,
  output logic   sqr_step,
  output logic   mul_start,
  output logic   step_digit,
  output logic   load_digits,
  output logic   load_rounds,
  output logic   step_round,
  output logic   mul_to_r,
  output logic   busy,
  output logic   done
);
  typedef enum logic [2:0] {
    st_idle,
    st_square,
    st_mul_run,
    st_write_r,
    st_inv_sqr
  } state_e;

  state_e state_q;
  state_e state_d;
  gf_op_e op_q;

  always_comb begin
    state_d = state_q;
    load_op = 1'b0;
    sqr_step = 1'b0;
    mul_start = 1'b0;
    step_digit = 1'b0;
    load_digits = 1'b0;
    load_rounds = 1'b0;
    step_round = 1'b0;
    mul_to_r = 1'b0;

    case (state_q)
      st_idle: begin
        if (start) begin
          case (op)
            op_sqr: begin
              load_op = 1'b1;
              state_d = st_square;
            end
            op_mul: begin
              load_op = 1'b1;
              mul_start = 1'b1;  // Takes a straight from the request
              load_digits = 1'b1;
              state_d = st_mul_run;
            end
            op_inv: begin
              load_op = 1'b1;
              load_rounds = 1'b1;
              state_d = st_inv_sqr;
            end
            default: state_d = st_idle;
          endcase
        end
      end
      st_square: begin
        sqr_step = 1'b1;
        state_d = st_idle;
      end
      // One inversion round starts here: s squares while the multiplier grabs r
      st_inv_sqr: begin
        sqr_step = 1'b1;
        mul_start = 1'b1;
        load_digits = 1'b1;
        state_d = st_mul_run;
      end
      st_mul_run: begin
        step_digit = 1'b1;
        if (digit_last) state_d = st_write_r;
      end
      st_write_r: begin
        mul_to_r = 1'b1;
        if (op_q == op_inv && !round_last) begin
          step_round = 1'b1;
          state_d = st_inv_sqr;
        end else begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= st_idle;
      op_q <= op_sqr;
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      state_q <= state_d;
      busy <= (state_d != st_idle);
      done <= (state_q != st_idle) && (state_d == st_idle);  // Falls with busy
      if (load_op) op_q <= op;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/gf233_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module gf233_datapath import gf233_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  gf_req_t  req,
  input  logic     load_op,
  input  logic     sqr_step,
  input  logic     mul_to_r,
  input  gf_elem_t product,
  output gf_elem_t mul_x,
  output gf_elem_t mul_y,
  output gf_rsp_t  rsp
);
  gf_elem_t s;
  gf_elem_t r;
  gf_elem_t b;
  gf_elem_t s_sq;
  gf_op_e   op_q;

  gf233_squarer sqr_i (
    .a (s),
    .d (s_sq)
  );

  always_ff @(posedge clk) begin
    if (load_op) begin
      s <= req.a;
      if (req.op == op_mul) b <= req.b;
    end else if (sqr_step && op_q != op_sqr) begin
      s <= s_sq;  // Next a^(2^i) of an inversion
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r <= '0;
      op_q <= op_sqr;
    end else if (load_op) begin
      op_q <= req.op;
      if (req.op == op_inv) r <= gf_elem_t'(1);
    end else if (sqr_step && op_q == op_sqr) begin
      r <= s_sq;
    end else if (mul_to_r) begin
      r <= product;
    end
  end

  // A multiply starts in the same cycle as the load, so x bypasses s then
  assign mul_x = load_op ? req.a : ((op_q == op_inv) ? r : s);
  assign mul_y = (op_q == op_inv) ? s : b;

  assign rsp = '{op: op_q, result: r};

endmodule

`default_nettype wire

// ==== rtl/gf233_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module gf233_unit import gf233_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    start,
  input  gf_req_t req,
  output logic    busy,
  output logic    done,
  output gf_rsp_t rsp
);
  logic     load_op;
  logic     sqr_step;
  logic     mul_start;
  logic     mul_to_r;
  logic     load_digits;
  logic     step_digit;
  logic     load_rounds;
  logic     step_round;
  logic     digit_last;
  logic     round_last;
  gf_elem_t mul_x;
  gf_elem_t mul_y;
  gf_elem_t product;

  gf233_ctrl_fsm fsm_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .op          (req.op),
    .digit_last  (digit_last),
    .round_last  (round_last),
    .load_op     (load_op),
    .sqr_step    (sqr_step),
    .mul_start   (mul_start),
    .step_digit  (step_digit),
    .load_digits (load_digits),
    .load_rounds (load_rounds),
    .step_round  (step_round),
    .mul_to_r    (mul_to_r),
    .busy        (busy),
    .done        (done)
  );

  gf233_step_counter cnt_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_digits (load_digits),
    .step_digit  (step_digit),
    .load_rounds (load_rounds),
    .step_round  (step_round),
    .digit_last  (digit_last),
    .round_last  (round_last)
  );

  gf233_datapath dp_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .load_op  (load_op),
    .sqr_step (sqr_step),
    .mul_to_r (mul_to_r),
    .product  (product),
    .mul_x    (mul_x),
    .mul_y    (mul_y),
    .rsp      (rsp)
  );

  gf233_digit_mul mul_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (mul_start),
    .step    (step_digit),
    .x       (mul_x),
    .y       (mul_y),
    .product (product)
  );

endmodule

`default_nettype wire

// ==== sim/gf233_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module gf233_chk import gf233_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  input logic    busy,
  input logic    done,
  input gf_rsp_t rsp
);

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done stayed high for more than one cycle");

  // Done is the registered end of an operation, so it lines up with busy going low
  a_done_busy: assert property (@(posedge clk) disable iff (!rst_n) done == $fell(busy))
    else $error("done and the falling edge of busy are not aligned");

  a_reset_idle: assert property (@(posedge clk) !rst_n |=> (!busy && !done))
    else $error("busy or done is high right after a reset cycle");

  a_rsp_known: assert property (@(posedge clk) disable iff (!rst_n) done |-> !$isunknown(rsp))
    else $error("rsp has unknown bits while done is high");

endmodule

`default_nettype wire

// ==== sim/gf233_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gf233_consts.svh"

module gf233_tb import gf233_pkg::*; ();
  localparam int max_cycles = 100000;  // Roughly 67000 cycles of tests plus margin

  logic    clk = 1'b0;
  logic    rst_n;
  logic    start;
  gf_req_t req;
  logic    busy;
  logic    done;
  gf_rsp_t rsp;

  logic [31:0] seed;
  int          cycle_cnt = 0;
  int          fail_cnt = 0;

  gf233_unit dut_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .req   (req),
    .busy  (busy),
    .done  (done),
    .rsp   (rsp)
  );

  bind gf233_unit gf233_chk chk_i (
    .clk   (clk),
    .rst_n (rst_n),
    .busy  (busy),
    .done  (done),
    .rsp   (rsp)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > max_cycles) begin
      $display("Regression failed");
      $fatal(1, "Timeout, the tests did not finish within %0d cycles", max_cycles);
    end
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Takes the upper half of each LCG word since its low bits have short periods
  function automatic gf_elem_t rand_elem();
    logic [31:0] w;
    gf_elem_t    e;
    e = '0;
    for (int k = 0; k < 15; k++) begin
      w = lcg_next();
      e = (e << 16) | gf_elem_t'(w[31:16]);
    end
    return e;
  endfunction

  // Shift-and-add product where x^233 folds back onto x^74 and x^0
  function automatic gf_elem_t model_mul(gf_elem_t x, gf_elem_t y);
    gf_elem_t p;
    logic     top;
    p = '0;
    for (int i = `GF_M - 1; i >= 0; i--) begin
      top = p[`GF_M-1];
      p = p << 1;
      if (top) p = p ^ gf_elem_t'(1) ^ (gf_elem_t'(1) << `GF_TAP);
      if (y[i]) p = p ^ x;
    end
    return p;
  endfunction

  task automatic check_elem(input string name, input gf_elem_t got, input gf_elem_t exp);
    if (got !== exp) begin
      fail_cnt++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
  endtask

  // Busy has to stay high on every cycle before done
  task automatic wait_done(inout int cycles);
    while (!done) begin
      check_elem("busy before done", gf_elem_t'(busy), gf_elem_t'(1));
      @(posedge clk);
      #2;
      cycles++;
    end
  endtask

  // Cycles count from the edge that samples start up to the one that raises done
  task automatic run_op(input gf_op_e kind, input gf_elem_t a, input gf_elem_t b,
                        output int cycles);
    req = '{op: kind, a: a, b: b};
    pulse_start();
    cycles = 1;
    wait_done(cycles);
  endtask

  task automatic square_case(input gf_elem_t a);
    int cycles;
    run_op(op_sqr, a, rand_elem(), cycles);
    check_elem("square rsp.result", rsp.result, model_mul(a, a));
    check_elem("square rsp.op", gf_elem_t'(rsp.op), gf_elem_t'(op_sqr));
    check_elem("square latency", gf_elem_t'(cycles), gf_elem_t'(2));
  endtask

  task automatic multiply_case(input gf_elem_t a, input gf_elem_t b);
    int cycles;
    run_op(op_mul, a, b, cycles);
    check_elem("multiply rsp.result", rsp.result, model_mul(a, b));
    check_elem("multiply rsp.op", gf_elem_t'(rsp.op), gf_elem_t'(op_mul));
    check_elem("multiply latency", gf_elem_t'(cycles), gf_elem_t'(32));
  endtask

  task automatic invert_case(input gf_elem_t a);
    int cycles;
    run_op(op_inv, a, '0, cycles);
    check_elem("invert rsp.op", gf_elem_t'(rsp.op), gf_elem_t'(op_inv));
    if (a == '0) begin
      check_elem("inverse of zero", rsp.result, '0);
    end else begin
      check_elem("a times inverse of a", model_mul(a, rsp.result), gf_elem_t'(1));
    end
  endtask

  // A second start, with an inversion request, arrives in the middle of a multiply
  task automatic busy_start_case();
    gf_elem_t a;
    gf_elem_t b;
    int       cycles;
    a = rand_elem();
    b = rand_elem();
    req = '{op: op_mul, a: a, b: b};
    pulse_start();
    repeat (10) begin
      @(posedge clk);
      #2;
    end
    req = '{op: op_inv, a: rand_elem(), b: rand_elem()};
    pulse_start();
    cycles = 12;
    wait_done(cycles);
    check_elem("busy multiply rsp.result", rsp.result, model_mul(a, b));
    check_elem("busy multiply latency", gf_elem_t'(cycles), gf_elem_t'(32));
    repeat (40) begin
      @(posedge clk);
      #2;
      check_elem("done after ignored start", gf_elem_t'(done), '0);
      check_elem("busy after ignored start", gf_elem_t'(busy), '0);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    start = 1'b0;
    req = '0;
    seed = 32'h5295_5e7f;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    check_elem("busy after reset", gf_elem_t'(busy), '0);
    check_elem("done after reset", gf_elem_t'(done), '0);
    check_elem("rsp.result after reset", rsp.result, '0);

    square_case('0);
    square_case(gf_elem_t'(1));
    square_case('1);
    for (int n = 0; n < 200; n++) square_case(rand_elem());

    multiply_case('0, rand_elem());
    multiply_case(rand_elem(), '0);
    multiply_case(gf_elem_t'(1), rand_elem());
    multiply_case(rand_elem(), gf_elem_t'(1));
    for (int n = 0; n < 200; n++) multiply_case(rand_elem(), rand_elem());

    invert_case('0);
    invert_case(gf_elem_t'(1));
    for (int n = 0; n < 6; n++) invert_case(rand_elem());

    busy_start_case();

    if (fail_cnt == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("Regression failed");
      $fatal(1, "%0d checks did not match", fail_cnt);
    end
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
rtl/gf233_pkg.sv
rtl/gf233_squarer.sv
rtl/gf233_digit_mul.sv
rtl/gf233_step_counter.sv
rtl/gf233_ctrl_fsm.sv
rtl/gf233_datapath.sv
rtl/gf233_unit.sv
sim/gf233_chk.sv
sim/gf233_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the GF(2^233) unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f all.f --top-module gf233_tb -Mdir obj_dir -o gf233_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/gf233_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi

exit 0
